/* run_sim.sh */
#!/bin/sh
# Builds the operand address testbench with Verilator and runs it

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f thread_offset.f \
    --top-module address_translate_tb -o address_translate_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/address_translate_sim > sim.log 2>&1
grep -qx "TESTBENCH PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* testbench/address_translate_tb.sv */
// Address translate testbench
// Round-robin reference model of the offset tables, checked against every output

`timescale 1ns/100ps

module address_translate_tb;

    import address_offset_pkg::*;

    localparam int THREAD_COUNT = 8;
    localparam int THREAD_WIDTH = $clog2(THREAD_COUNT);
    localparam int SLOT_COUNT   = 2**PO_SLOT_WIDTH;
    localparam int DRAIN_LIMIT  = 20;
    // Indirect window is four words starting at 0x3F0
    localparam logic [ADDR_WIDTH-1:0] WINDOW_BASE = 10'h3F0;
    localparam logic [ADDR_WIDTH-1:0] SHARED_IDLE = 10'h300;
    localparam instr_status_t STATUS_OK        = '{io_ready: 1'b1, cancel: 1'b0};
    localparam instr_status_t STATUS_ANNULLED  = '{io_ready: 1'b0, cancel: 1'b0};
    localparam instr_status_t STATUS_CANCELLED = '{io_ready: 1'b1, cancel: 1'b1};

    // One issued instruction, held until its result reaches the output
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    expected;
        logic [THREAD_WIDTH-1:0]  thread;
        logic                     indirect;
        logic [PO_SLOT_WIDTH-1:0] slot;
        instr_status_t            status_prev;
        po_write_t                po_w;
        do_write_t                do_w;
    } issue_record_t;

    logic                  clock = 1'b0;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] raw_addr;
    instr_status_t         status_previous;
    instr_status_t         status_current;
    po_write_t             po_write;
    do_write_t             do_write;
    logic [ADDR_WIDTH-1:0] offset_addr;

    // ------------------------------
    // Reference model state
    logic [ADDR_WIDTH-1:0]   model_do [THREAD_COUNT];
    po_entry_t               model_po [THREAD_COUNT][SLOT_COUNT];
    issue_record_t           pending [$];
    logic [THREAD_WIDTH-1:0] model_thread = '0;
    logic [ADDR_WIDTH-1:0]   expected_addr = '0;
    logic                    check_enable = 1'b0;
    int                      checked_count = 0;
    int                      issued_count = 0;
    string                   test_name = "reset";

    address_translate_top #(
        .THREAD_COUNT (THREAD_COUNT)
    ) address_translate_top_i (
        .clock           (clock),
        .rst             (rst),
        .raw_addr        (raw_addr),
        .status_previous (status_previous),
        .status_current  (status_current),
        .po_write        (po_write),
        .do_write        (do_write),
        .offset_addr     (offset_addr)
    );

    always #4 clock = ~clock;

    // Offset advanced by its signed increment, wrapping over the address space
    function automatic logic [ADDR_WIDTH-1:0] step_offset(input po_entry_t entry);
        logic [ADDR_WIDTH-1:0] step;
        step = {{(ADDR_WIDTH-PO_INCR_WIDTH){entry.incr[PO_INCR_WIDTH-1]}}, entry.incr};
        return entry.offset + step;
    endfunction

    function automatic logic status_live(input instr_status_t status);
        return status.io_ready && !status.cancel;
    endfunction

    function automatic po_entry_t random_entry();
        po_entry_t entry;
        entry.offset = ADDR_WIDTH'($urandom);
        entry.incr   = PO_INCR_WIDTH'($urandom);
        return entry;
    endfunction

    // Anywhere in the top quarter except the indirect window
    function automatic logic [ADDR_WIDTH-1:0] random_shared_addr();
        logic [ADDR_WIDTH-1:0] addr;
        addr = SHARED_IDLE | ADDR_WIDTH'($urandom % 256);
        if (addr >= WINDOW_BASE && addr < WINDOW_BASE + SLOT_COUNT) begin
            addr = SHARED_IDLE;
        end
        return addr;
    endfunction

    function automatic instr_status_t random_status();
        int pick;
        pick = $urandom % 4;
        return (pick == 0) ? STATUS_ANNULLED : (pick == 1) ? STATUS_CANCELLED : STATUS_OK;
    endfunction

    // ------------------------------
    // Model, one step per rising edge

    always @(posedge clock) begin
        issue_record_t rec;
        issue_record_t done;
        if (rst) begin
            pending.delete();
            model_thread = '0;
            check_enable = 1'b0;
        end else begin
            // The oldest instruction reaches the output and commits its writes
            if (pending.size() == 2) begin
                done = pending.pop_front();
                expected_addr = done.expected;
                check_enable = 1'b1;
                checked_count++;
                if (done.indirect && status_live(status_current)) begin
                    model_po[done.thread][done.slot].offset =
                        step_offset(model_po[done.thread][done.slot]);
                end
                // External write lands after the step, so it wins
                if (status_live(done.status_prev) && done.po_w.wren) begin
                    model_po[done.thread][done.po_w.slot] = done.po_w.entry;
                end
                if (status_live(done.status_prev) && done.do_w.wren) begin
                    model_do[done.thread] = done.do_w.offset;
                end
            end
            rec.thread      = model_thread;
            rec.indirect    = raw_addr >= WINDOW_BASE && raw_addr < WINDOW_BASE + SLOT_COUNT;
            rec.slot        = raw_addr[PO_SLOT_WIDTH-1:0];
            rec.status_prev = status_previous;
            rec.po_w        = po_write;
            rec.do_w        = do_write;
            if (rec.indirect) begin
                rec.expected = raw_addr + model_po[model_thread][rec.slot].offset;
            end else if (raw_addr[ADDR_WIDTH-1 -: 2] == 2'b11) begin
                rec.expected = raw_addr;
            end else begin
                rec.expected = raw_addr + model_do[model_thread];
            end
            pending.push_back(rec);
            issued_count++;
            model_thread = (int'(model_thread) == THREAD_COUNT - 1) ? '0 : model_thread + 1'b1;
        end
    end

    output_matches: assert property (@(negedge clock) disable iff (rst || !check_enable)
        offset_addr == expected_addr)
    else begin
        $display("ERR %s expected %h actual %h", test_name, expected_addr, offset_addr);
        $display("TESTBENCH FAILED");
        $fatal(1, "Translated address does not match the reference model");
    end

    // One instruction per call, driven on the falling edge
    task automatic issue_instruction(
        input logic [ADDR_WIDTH-1:0] addr,
        input instr_status_t         prev,
        input instr_status_t         cur,
        input po_write_t             pw,
        input do_write_t             dw
    );
        @(negedge clock);
        raw_addr        = addr;
        status_previous = prev;
        status_current  = cur;
        po_write        = pw;
        do_write        = dw;
    endtask

    initial begin
        int pass;
        int cycle;
        int pick;
        int wait_cycles;
        int target;
        po_write_t pw;
        do_write_t dw;
        void'($urandom(32'hb649ac79));
        rst             = 1'b1;
        raw_addr        = SHARED_IDLE;
        status_previous = STATUS_OK;
        status_current  = STATUS_OK;
        po_write        = '0;
        do_write        = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Every thread and slot is written before anything reads it
        test_name = "programming";
        for (pass = 0; pass < SLOT_COUNT; pass++) begin
            for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
                pw = '{wren: 1'b1, slot: PO_SLOT_WIDTH'(pass), entry: random_entry()};
                dw = '{wren: 1'b1, offset: ADDR_WIDTH'($urandom)};
                issue_instruction(random_shared_addr(), STATUS_OK, STATUS_OK, pw, dw);
            end
        end
        test_name = "direct";
        for (cycle = 0; cycle < 2 * THREAD_COUNT; cycle++) begin
            issue_instruction(ADDR_WIDTH'($urandom % 768), STATUS_OK, STATUS_OK, '0, '0);
        end
        test_name = "shared";
        for (cycle = 0; cycle < 2 * THREAD_COUNT; cycle++) begin
            issue_instruction(random_shared_addr(), STATUS_OK, STATUS_OK, '0, '0);
        end

        // Slot 3 gets a small offset and a step of -8 so it wraps below zero
        test_name = "indirect";
        for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
            pw = '{wren: 1'b1, slot: 2'd3, entry: '{offset: ADDR_WIDTH'(cycle), incr: 4'h8}};
            issue_instruction(SHARED_IDLE, STATUS_OK, STATUS_OK, pw, '0);
        end
        for (pass = 0; pass < 3 * SLOT_COUNT; pass++) begin
            for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
                issue_instruction(WINDOW_BASE + (pass % SLOT_COUNT), STATUS_OK, STATUS_OK,
                                  '0, '0);
            end
        end

        test_name = "increment suppressed";
        for (cycle = 0; cycle < 2 * THREAD_COUNT; cycle++) begin
            issue_instruction(WINDOW_BASE + 2, STATUS_OK,
                              cycle[0] ? STATUS_CANCELLED : STATUS_ANNULLED, '0, '0);
        end
        for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
            issue_instruction(WINDOW_BASE + 2, STATUS_OK, STATUS_OK, '0, '0);
        end

        // Dropped writes, then a write colliding with the step of the same slot
        test_name = "write gating";
        for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
            pw = '{wren: 1'b1, slot: PO_SLOT_WIDTH'(cycle), entry: random_entry()};
            dw = '{wren: 1'b1, offset: ADDR_WIDTH'($urandom)};
            issue_instruction(SHARED_IDLE, cycle[0] ? STATUS_CANCELLED : STATUS_ANNULLED,
                              STATUS_OK, pw, dw);
        end
        for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
            pw = '{wren: 1'b1, slot: PO_SLOT_WIDTH'(cycle), entry: random_entry()};
            issue_instruction(WINDOW_BASE + (cycle % SLOT_COUNT), STATUS_OK, STATUS_OK, pw, '0);
        end
        for (pass = 0; pass < SLOT_COUNT; pass++) begin
            for (cycle = 0; cycle < THREAD_COUNT; cycle++) begin
                issue_instruction((cycle % 2) ? WINDOW_BASE + pass : 10'h040, STATUS_OK,
                                  STATUS_OK, '0, '0);
            end
        end

        test_name = "random traffic";
        for (cycle = 0; cycle < 400; cycle++) begin
            pick = $urandom % 3;
            pw   = '{wren: 1'($urandom), slot: PO_SLOT_WIDTH'($urandom), entry: random_entry()};
            dw   = '{wren: 1'($urandom), offset: ADDR_WIDTH'($urandom)};
            issue_instruction((pick == 0) ? WINDOW_BASE + ($urandom % SLOT_COUNT) :
                              (pick == 1) ? random_shared_addr() : ADDR_WIDTH'($urandom % 768),
                              random_status(), random_status(), pw, dw);
        end

        // Let the last issued results reach the output
        // The instruction driven last is only sampled on the coming rising edge
        test_name   = "drain";
        target      = issued_count + 1;
        wait_cycles = 0;
        while (checked_count < target && wait_cycles < DRAIN_LIMIT) begin
            issue_instruction(SHARED_IDLE, STATUS_OK, STATUS_OK, '0, '0);
            wait_cycles++;
        end
        // One more falling edge so the compare of the last result has run
        @(negedge clock);
        if (checked_count < target) begin
            $display("Timeout: issued results never reached the output");
            $display("TESTBENCH FAILED");
            $fatal(1, "Pipeline drain timed out");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* thread_offset.f */
verilog/address_offset_pkg.sv
verilog/operand_decoder.sv
verilog/thread_counter.sv
verilog/programmed_offset_memory.sv
verilog/address_offset_unit.sv
verilog/address_translate_top.sv
testbench/address_translate_tb.sv

/* verilog/address_offset_pkg.sv */
// Address offset package
// Shared address map, operand classes and write port types for the operand stage

package address_offset_pkg;

    // Operand address width, also the width of every offset
    localparam int ADDR_WIDTH    = 10;
    // Four programmed offset slots per thread
    localparam int PO_SLOT_WIDTH = 2;
    // Signed post-increment width
    localparam int PO_INCR_WIDTH = 4;

    // Top two address bits of 2'b11 select shared memory
    localparam logic [1:0] SHARED_BASE   = 2'b11;
    // Top six bits of the indirect window, placing it at 0x3F0
    // The bits between this tag and the slot must be zero, so the window
    // covers 0x3F0 to 0x3F3 and the rest of 0x3F4..0x3FF stays shared
    localparam logic [5:0] INDIRECT_BASE = 6'h3F;

    typedef enum logic [1:0] {
        class_direct,
        class_shared,
        class_indirect
    } operand_class_t;

    // One programmed offset table entry
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    offset;
        logic [PO_INCR_WIDTH-1:0] incr;
    } po_entry_t;

    typedef struct packed {
        logic                     wren;
        logic [PO_SLOT_WIDTH-1:0] slot;
        po_entry_t                entry;
    } po_write_t;

    typedef struct packed {
        logic                  wren;
        logic [ADDR_WIDTH-1:0] offset;
    } do_write_t;

    // An instruction is annulled when io_ready is low
    typedef struct packed {
        logic io_ready;
        logic cancel;
    } instr_status_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    addr;
        operand_class_t           op_class;
        logic [PO_SLOT_WIDTH-1:0] slot;
    } decoded_operand_t;

endpackage

/* verilog/address_offset_unit.sv */
// Address offset unit
// Aligns write strobes, keeps per-thread offsets and adds the chosen one

`timescale 1ns/100ps

module address_offset_unit #(
    parameter int THREAD_COUNT = 8
) (
    input  logic                                      clock,
    input  logic                                      rst,
    input  address_offset_pkg::decoded_operand_t      operand,
    input  address_offset_pkg::instr_status_t         status_previous,
    input  address_offset_pkg::instr_status_t         status_current,
    input  address_offset_pkg::po_write_t             po_write,
    input  address_offset_pkg::do_write_t             do_write,
    output logic [address_offset_pkg::ADDR_WIDTH-1:0] offset_addr
);

    import address_offset_pkg::*;

    localparam int THREAD_WIDTH = $clog2(THREAD_COUNT);
    // Stages from operand input to offset_addr
    localparam int PIPE_DEPTH   = 2;

    logic [THREAD_WIDTH-1:0] read_thread;
    logic [THREAD_WIDTH-1:0] write_thread;

    logic             valid_s1;
    logic             valid_s2;
    decoded_operand_t operand_s1;
    decoded_operand_t operand_s2;
    instr_status_t    status_prev_s1;
    instr_status_t    status_prev_s2;
    po_write_t        po_write_s1;
    po_write_t        po_write_s2;
    do_write_t        do_write_s1;
    do_write_t        do_write_s2;

    logic                  commit_ok;
    po_write_t             po_write_gated;
    logic                  do_wren_gated;
    logic [ADDR_WIDTH-1:0] do_table [THREAD_COUNT];
    logic [ADDR_WIDTH-1:0] default_offset;
    logic [ADDR_WIDTH-1:0] programmed_offset;
    logic [ADDR_WIDTH-1:0] selected_offset;
    logic [ADDR_WIDTH-1:0] offset_s2;
    logic                  incr_enable;

    // ------------------------------
    // Thread numbers

    thread_counter #(
        .THREAD_COUNT (THREAD_COUNT),
        .RESET_THREAD (0)
    ) read_counter_i (
        .clock  (clock),
        .rst    (rst),
        .thread (read_thread)
    );

    // Trails the read count by the pipe depth so writes hit the output's thread
    // A second counter is cheaper than carrying the thread number down the pipe
    thread_counter #(
        .THREAD_COUNT (THREAD_COUNT),
        .RESET_THREAD (THREAD_COUNT - PIPE_DEPTH)
    ) write_counter_i (
        .clock  (clock),
        .rst    (rst),
        .thread (write_thread)
    );

    // ------------------------------
    // Delay lines

    // Valid bits keep the first two cycles after reset from writing anything
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= 1'b1;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clock) begin
        operand_s1     <= operand;
        operand_s2     <= operand_s1;
        status_prev_s1 <= status_previous;
        status_prev_s2 <= status_prev_s1;
        po_write_s1    <= po_write;
        po_write_s2    <= po_write_s1;
        do_write_s1    <= do_write;
        do_write_s2    <= do_write_s1;
    end

    // Writes from an annulled or cancelled instruction are dropped
    always_comb begin
        commit_ok           = valid_s2 && status_prev_s2.io_ready && !status_prev_s2.cancel;
        po_write_gated      = po_write_s2;
        po_write_gated.wren = po_write_s2.wren && commit_ok;
        do_wren_gated       = do_write_s2.wren && commit_ok;
    end

    // ------------------------------
    // Offset tables

    always_ff @(posedge clock) begin
        if (do_wren_gated) begin
            do_table[write_thread] <= do_write_s2.offset;
        end
        default_offset <= do_table[read_thread];
    end

    // Slot post-increment follows the indirect operand now at stage 2
    assign incr_enable = valid_s2 && (operand_s2.op_class == class_indirect);

    programmed_offset_memory #(
        .THREAD_COUNT (THREAD_COUNT)
    ) po_memory_i (
        .clock             (clock),
        .rst               (rst),
        .read_thread       (read_thread),
        .write_thread      (write_thread),
        .read_slot         (operand.slot),
        .incr_slot         (operand_s2.slot),
        .incr_enable       (incr_enable),
        .status_current    (status_current),
        .external_write    (po_write_gated),
        .programmed_offset (programmed_offset)
    );

    // ------------------------------
    // Offset select and add

    // Indirect takes its slot, shared takes none, direct takes the thread default
    always_comb begin
        case (operand_s1.op_class)
            class_indirect: selected_offset = programmed_offset;
            class_shared:   selected_offset = '0;
            default:        selected_offset = default_offset;
        endcase
    end

    always_ff @(posedge clock) begin
        offset_s2 <= selected_offset;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            offset_addr <= '0;
        end else begin
            offset_addr <= operand_s2.addr + offset_s2;
        end
    end

endmodule

/* verilog/address_translate_top.sv */
// Address translate top
// Operand decode followed by the two-stage thread offset unit

`timescale 1ns/100ps

module address_translate_top #(
    parameter int THREAD_COUNT = 8
) (
    input  logic                                      clock,
    input  logic                                      rst,
    // One raw operand address per cycle, threads in round-robin order
    input  logic [address_offset_pkg::ADDR_WIDTH-1:0] raw_addr,
    // Status of the instruction issuing the offset writes
    input  address_offset_pkg::instr_status_t         status_previous,
    // Status of the instruction whose result is at the output
    input  address_offset_pkg::instr_status_t         status_current,
    input  address_offset_pkg::po_write_t             po_write,
    input  address_offset_pkg::do_write_t             do_write,
    // Translated address, two cycles after raw_addr
    output logic [address_offset_pkg::ADDR_WIDTH-1:0] offset_addr
);

    import address_offset_pkg::*;

    decoded_operand_t operand;

    // Classification is combinational and feeds stage 0 directly
    operand_decoder operand_decoder_i (
        .raw_addr (raw_addr),
        .operand  (operand)
    );

    address_offset_unit #(
        .THREAD_COUNT (THREAD_COUNT)
    ) address_offset_unit_i (
        .clock           (clock),
        .rst             (rst),
        .operand         (operand),
        .status_previous (status_previous),
        .status_current  (status_current),
        .po_write        (po_write),
        .do_write        (do_write),
        .offset_addr     (offset_addr)
    );

endmodule

/* verilog/operand_decoder.sv */
// Operand decoder
// Sorts a raw operand address into shared, direct or indirect memory

`timescale 1ns/100ps

module operand_decoder (
    input  logic [address_offset_pkg::ADDR_WIDTH-1:0] raw_addr,
    output address_offset_pkg::decoded_operand_t      operand
);

    import address_offset_pkg::*;

    localparam int INDIRECT_TAG_WIDTH = $bits(INDIRECT_BASE);
    localparam int SHARED_TAG_WIDTH   = $bits(SHARED_BASE);
    // Bits sitting between the indirect tag and the slot index
    localparam int GAP_MSB            = ADDR_WIDTH - INDIRECT_TAG_WIDTH - 1;

    logic indirect_hit;
    logic shared_hit;

    // Tag compares
    // The indirect window sits inside the shared region
    always_comb begin
        indirect_hit = (raw_addr[ADDR_WIDTH-1 -: INDIRECT_TAG_WIDTH] == INDIRECT_BASE)
                    && (raw_addr[GAP_MSB:PO_SLOT_WIDTH] == '0);
        shared_hit   = (raw_addr[ADDR_WIDTH-1 -: SHARED_TAG_WIDTH] == SHARED_BASE);
    end

    always_comb begin
        operand.addr = raw_addr;
        // Slot comes straight from the low address bits
        operand.slot = raw_addr[PO_SLOT_WIDTH-1:0];
        // Indirect is checked first so the window wins over shared
        if (indirect_hit) begin
            operand.op_class = class_indirect;
        end else if (shared_hit) begin
            operand.op_class = class_shared;
        end else begin
            operand.op_class = class_direct;
        end
    end

endmodule

/* verilog/programmed_offset_memory.sv */
// Programmed offset memory
// Per-thread offset and increment slots with post-increment write-back

`timescale 1ns/100ps

module programmed_offset_memory #(
    parameter int THREAD_COUNT = 8
) (
    input  logic                                         clock,
    input  logic                                         rst,
    input  logic [$clog2(THREAD_COUNT)-1:0]              read_thread,
    input  logic [$clog2(THREAD_COUNT)-1:0]              write_thread,
    input  logic [address_offset_pkg::PO_SLOT_WIDTH-1:0] read_slot,
    input  logic [address_offset_pkg::PO_SLOT_WIDTH-1:0] incr_slot,
    input  logic                                         incr_enable,
    input  address_offset_pkg::instr_status_t            status_current,
    input  address_offset_pkg::po_write_t                external_write,
    output logic [address_offset_pkg::ADDR_WIDTH-1:0]    programmed_offset
);

    import address_offset_pkg::*;

    localparam int SLOT_COUNT = 2**PO_SLOT_WIDTH;
    localparam int SIGN_WIDTH = ADDR_WIDTH - PO_INCR_WIDTH;

    // One entry per thread and slot
    po_entry_t po_table [THREAD_COUNT][SLOT_COUNT];

    // Entry read at stage 0, then carried along for the write-back
    po_entry_t entry_s1;
    po_entry_t entry_s2;

    logic [ADDR_WIDTH-1:0] incr_extended;
    po_entry_t             incr_entry;
    logic                  incr_commit;
    logic                  external_commit;

    // ------------------------------
    // Read side

    always_ff @(posedge clock) begin
        entry_s1 <= po_table[read_thread][read_slot];
        entry_s2 <= entry_s1;
    end

    assign programmed_offset = entry_s1.offset;

    // ------------------------------
    // Post-increment

    // Increment is signed, so negative steps wrap modulo the address space
    always_comb begin
        incr_extended     = {{SIGN_WIDTH{entry_s2.incr[PO_INCR_WIDTH-1]}}, entry_s2.incr};
        incr_entry.offset = entry_s2.offset + incr_extended;
        incr_entry.incr   = entry_s2.incr;
    end

    // The instruction now at the output must still be live to step its slot
    always_comb begin
        incr_commit     = incr_enable && status_current.io_ready
                       && !status_current.cancel && !rst;
        external_commit = external_write.wren && !rst;
    end

    // ------------------------------
    // Write side

    // Both writes land on the thread whose result is at the output
    // The external write is applied last, so it wins on a slot collision
    always_ff @(posedge clock) begin
        if (incr_commit) begin
            po_table[write_thread][incr_slot] <= incr_entry;
        end
        if (external_commit) begin
            po_table[write_thread][external_write.slot] <= external_write.entry;
        end
    end

endmodule

/* verilog/thread_counter.sv */
// Thread counter
// Round-robin thread number, one step per clock, loaded on reset

`timescale 1ns/100ps

module thread_counter #(
    parameter int THREAD_COUNT = 8,
    parameter int RESET_THREAD = 0
) (
    input  logic                              clock,
    input  logic                              rst,
    output logic [$clog2(THREAD_COUNT)-1:0]   thread
);

    localparam int THREAD_WIDTH = $clog2(THREAD_COUNT);
    localparam logic [THREAD_WIDTH-1:0] RESET_VALUE = THREAD_WIDTH'(RESET_THREAD);
    localparam logic [THREAD_WIDTH-1:0] LAST_THREAD = THREAD_WIDTH'(THREAD_COUNT - 1);

    // Wraps explicitly so a count that is not a power of two still works
    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= RESET_VALUE;
        end else if (thread == LAST_THREAD) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

endmodule
